/* hdl/mul_config.svh */
// width settings for the iterative radix-4 booth multiplier
// stride must be even, divide the width and stay below it
// cpa stride must divide the width
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// operand width, product is twice this
`define MUL_WIDTH 32

// multiplier bits consumed per calc cycle
`define MUL_STRIDE 8

// high-half bits resolved per cpa cycle
`define MUL_CPA_STRIDE 16

// carry-save register width
// stride for the most shifted row, width+3 for a partial product, 1 for carry
`define MUL_CSA_WIDTH (`MUL_STRIDE + `MUL_WIDTH + 4)

`endif

/* hdl/mul_pkg.sv */
// shared types for the booth multiplier
// digit bits are {negate, double, nonzero}
`default_nettype none

package mul_pkg;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_cpa,
    st_done
  } mul_state_e;

  typedef enum logic [2:0] {
    bd_zero = 3'b000,
    bd_pos1 = 3'b001,
    bd_pos2 = 3'b011,
    bd_neg1 = 3'b101,
    bd_neg2 = 3'b111 // -2A, complement and shift, +1 comes as sign fix
  } booth_digit_e;

endpackage

`default_nettype wire

/* hdl/mul_sequencer.sv */
// controller for one product at a time
// width/stride calc cycles, then width/cpa_stride cpa cycles, then done
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module mul_sequencer import mul_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  logic yumi_i,
  output logic ready_o,
  output logic v_o,
  output logic load_o,
  output logic calc_o,
  output logic cpa_first_o,
  output logic cpa_o
);

  localparam int calc_lv_lp = `MUL_WIDTH / `MUL_STRIDE;
  localparam int cpa_lv_lp  = `MUL_WIDTH / `MUL_CPA_STRIDE;
  localparam int calc_cw_lp = (calc_lv_lp > 1) ? $clog2(calc_lv_lp) : 1;
  localparam int cpa_cw_lp  = (cpa_lv_lp > 1) ? $clog2(cpa_lv_lp) : 1;

  mul_state_e            state_r;
  logic [calc_cw_lp-1:0] calc_cnt_r;
  logic [cpa_cw_lp-1:0]  cpa_cnt_r;
  logic                  calc_last;
  logic                  cpa_last;

  assign calc_last = (calc_cnt_r == calc_cw_lp'(calc_lv_lp - 1));
  assign cpa_last  = (cpa_cnt_r == cpa_cw_lp'(cpa_lv_lp - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
    end else begin
      case (state_r)
        st_idle: if (v_i) state_r <= st_calc;
        st_calc: if (calc_last) state_r <= st_cpa;
        st_cpa:  if (cpa_last) state_r <= st_done;
        default: if (yumi_i) state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || load_o) begin
      calc_cnt_r <= '0;
      cpa_cnt_r  <= '0;
    end else if (calc_o) begin
      calc_cnt_r <= calc_cnt_r + 1'b1;
    end else if (cpa_o) begin
      cpa_cnt_r <= cpa_cnt_r + 1'b1;
    end
  end

  assign ready_o     = (state_r == st_idle);
  assign v_o         = (state_r == st_done);
  assign load_o      = ready_o & v_i; // accept edge
  assign calc_o      = (state_r == st_calc);
  assign cpa_o       = (state_r == st_cpa);
  assign cpa_first_o = cpa_o & (cpa_cnt_r == '0);

endmodule

`default_nettype wire

/* hdl/booth_selector.sv */
// one partial product from A and a booth digit
// negation is one's complement only, the +1 is added by the caller
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module booth_selector import mul_pkg::*; #(
  parameter bit leading = 1'b0
) (
  input  logic [`MUL_WIDTH:0]           op_i,
  input  booth_digit_e                  digit_i,
  output logic [`MUL_WIDTH+2+leading:0] pp_o
);

  logic [`MUL_WIDTH:0] pos_neg;
  logic [`MUL_WIDTH:0] nz;
  logic [`MUL_WIDTH:0] pd;
  logic                e;

  assign pos_neg = digit_i[2] ? ~op_i : op_i;
  assign nz      = digit_i[0] ? pos_neg : '0;
  assign pd      = digit_i[1] ? {nz[`MUL_WIDTH-1:0], digit_i[2]} : nz;
  assign e       = nz[`MUL_WIDTH]; // sign of the row, kept across the doubling

  // sign extension encoding
  if (leading) begin : g_lead
    assign pp_o = {~e, e, e, pd};
  end else begin : g_row
    assign pp_o = {1'b1, ~e, pd};
  end

endmodule

`default_nettype wire

/* hdl/booth_recoder.sv */
// radix-4 recoding of operand b, done once at accept
// digit 0 becomes the leading partial product right away
// remaining digits leave stride/2 at a time, lowest first
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module booth_recoder import mul_pkg::*; (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                load_i,
  input  logic                                calc_i,
  input  logic [`MUL_WIDTH-1:0]               opa_i,
  input  logic [`MUL_WIDTH-1:0]               opb_i,
  input  logic                                signed_i,
  output logic [`MUL_WIDTH:0]                 opa_ext_o,
  output booth_digit_e [`MUL_STRIDE/2-1:0]    digits_o,
  output logic                                sign_fix_o,
  output logic [`MUL_WIDTH+3:0]               first_pp_o
);

  localparam int ndig_lp = `MUL_WIDTH / 2;
  localparam int step_lp = `MUL_STRIDE / 2;

  logic                     opb_sign;
  logic [`MUL_WIDTH+2:0]    opb_ext;
  logic [`MUL_WIDTH:0]      opa_ext;
  booth_digit_e [ndig_lp:0] code;

  booth_digit_e [ndig_lp-1:0] digits_r;
  logic                       sign_fix_r;
  logic [`MUL_WIDTH:0]        opa_r;

  function automatic booth_digit_e encode(input logic [2:0] bits);
    booth_digit_e d;
    case (bits)
      3'b001, 3'b010: d = bd_pos1;
      3'b011:         d = bd_pos2;
      3'b100:         d = bd_neg2;
      3'b101, 3'b110: d = bd_neg1;
      default:        d = bd_zero;
    endcase
    return d;
  endfunction

  assign opb_sign = signed_i & opb_i[`MUL_WIDTH-1];
  assign opb_ext  = {opb_sign, opb_sign, opb_i, 1'b0}; // implicit b[-1] = 0
  assign opa_ext  = {signed_i & opa_i[`MUL_WIDTH-1], opa_i};

  // overlapping triplets, one per digit
  always_comb begin
    for (int i = 0; i <= ndig_lp; i++) begin
      code[i] = encode(opb_ext[2*i +: 3]);
    end
  end

  booth_selector #(
    .leading(1'b1)
  ) u_first_sel (
    .op_i   (opa_ext),
    .digit_i(code[0]),
    .pp_o   (first_pp_o)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < ndig_lp; i++) begin
        digits_r[i] <= bd_zero;
      end
      sign_fix_r <= 1'b0;
    end else if (load_i) begin
      for (int i = 0; i < ndig_lp; i++) begin
        digits_r[i] <= code[i+1];
      end
      sign_fix_r <= code[0][2];
    end else if (calc_i) begin
      for (int i = 0; i < ndig_lp; i++) begin
        if (i < ndig_lp - step_lp) digits_r[i] <= digits_r[i+step_lp];
        else digits_r[i] <= bd_zero;
      end
      sign_fix_r <= digits_r[step_lp-1][2]; // +1 owed by last consumed digit
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) opa_r <= opa_ext;
  end

  assign opa_ext_o  = opa_r;
  assign digits_o   = digits_r[step_lp-1:0];
  assign sign_fix_o = sign_fix_r;

endmodule

`default_nettype wire

/* hdl/csa_accumulator.sv */
// carry-save accumulation, stride/2 partial products per calc cycle
// 3:2 rows in a plain chain, no 4:2 option
// low stride bits retire through the tail adder every cycle
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module csa_accumulator import mul_pkg::*; (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             load_i,
  input  logic                             calc_i,
  input  logic                             cpa_i,
  input  logic [`MUL_WIDTH:0]              opa_ext_i,
  input  booth_digit_e [`MUL_STRIDE/2-1:0] digits_i,
  input  logic                             sign_fix_i,
  input  logic [`MUL_WIDTH+3:0]            first_pp_i,
  output logic [`MUL_STRIDE-1:0]           tail_sum_o,
  output logic                             tail_carry_o,
  output logic [`MUL_CPA_STRIDE-1:0]       hi_a_o,
  output logic [`MUL_CPA_STRIDE-1:0]       hi_b_o
);

  localparam int step_lp = `MUL_STRIDE / 2;
  localparam int cw_lp   = `MUL_CSA_WIDTH;

  logic [cw_lp-1:0] sum_r;
  logic [cw_lp-1:0] carry_r;

  logic [`MUL_WIDTH+2:0] pp   [step_lp];
  logic [cw_lp-1:0]      rows [step_lp+2];
  logic [cw_lp-1:0]      acc_s [step_lp+1];
  logic [cw_lp-1:0]      acc_c [step_lp+1];
  logic [`MUL_STRIDE:0]  tail;

  for (genvar g = 0; g < step_lp; g++) begin : g_pp
    booth_selector #(
      .leading(1'b0)
    ) u_sel (
      .op_i   (opa_ext_i),
      .digit_i(digits_i[g]),
      .pp_o   (pp[g])
    );

    // pp sits at 2g+2, the previous digit's +1 at 2g
    if (g == 0) begin : g_row0
      assign rows[g] = cw_lp'({pp[g], 1'b0, sign_fix_i});
    end else begin : g_rown
      assign rows[g] = cw_lp'({pp[g], 1'b0, digits_i[g-1][2]}) << (2 * g);
    end
  end

  // running sum and carry, already retired bits dropped
  assign rows[step_lp]   = sum_r >> `MUL_STRIDE;
  assign rows[step_lp+1] = carry_r >> `MUL_STRIDE;

  assign acc_s[0] = rows[0];
  assign acc_c[0] = rows[1];

  for (genvar k = 0; k < step_lp; k++) begin : g_csa
    logic [cw_lp-1:0] x;
    logic [cw_lp-1:0] maj;

    assign x   = rows[k+2];
    assign maj = (acc_s[k] & acc_c[k]) | (acc_s[k] & x) | (acc_c[k] & x);

    assign acc_s[k+1] = acc_s[k] ^ acc_c[k] ^ x;
    assign acc_c[k+1] = {maj[cw_lp-2:0], 1'b0};
  end

  assign tail = {1'b0, sum_r[`MUL_STRIDE-1:0]} + {1'b0, carry_r[`MUL_STRIDE-1:0]};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sum_r   <= '0;
      carry_r <= '0;
    end else if (load_i) begin
      sum_r   <= {first_pp_i, {`MUL_STRIDE{1'b0}}};
      carry_r <= '0;
    end else if (calc_i) begin
      sum_r   <= acc_s[step_lp];
      carry_r <= {acc_c[step_lp][cw_lp-1:1], tail[`MUL_STRIDE]}; // lsb is free after shift
    end else if (cpa_i) begin
      sum_r   <= sum_r >> `MUL_CPA_STRIDE;
      carry_r <= carry_r >> `MUL_CPA_STRIDE;
    end
  end

  assign tail_sum_o   = tail[`MUL_STRIDE-1:0];
  assign tail_carry_o = tail[`MUL_STRIDE];
  assign hi_a_o       = sum_r[`MUL_STRIDE +: `MUL_CPA_STRIDE];
  assign hi_b_o       = carry_r[`MUL_STRIDE +: `MUL_CPA_STRIDE];

endmodule

`default_nettype wire

/* hdl/result_cpa.sv */
// assembles the product, low half from the tail sums
// high half through a carry-select adder, one slice per cpa cycle
// the first tail chunk is only the seed padding and falls off the low end
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module result_cpa (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         calc_i,
  input  logic                         cpa_first_i,
  input  logic                         cpa_i,
  input  logic [`MUL_STRIDE-1:0]       tail_sum_i,
  input  logic                         tail_carry_i,
  input  logic [`MUL_CPA_STRIDE-1:0]   hi_a_i,
  input  logic [`MUL_CPA_STRIDE-1:0]   hi_b_i,
  output logic [2*`MUL_WIDTH-1:0]      result_o
);

  logic [`MUL_WIDTH-1:0] low_r;
  logic [`MUL_WIDTH-1:0] high_r;
  logic                  slice_carry_r;

  logic [`MUL_WIDTH+`MUL_STRIDE-1:0]     low_cat;
  logic [`MUL_WIDTH+`MUL_CPA_STRIDE-1:0] high_cat;
  logic [`MUL_CPA_STRIDE:0]              sum0;
  logic [`MUL_CPA_STRIDE:0]              sum1;
  logic [`MUL_CPA_STRIDE:0]              slice;
  logic                                  cin;

  // both carry-in cases ready before the select arrives
  assign sum0 = {1'b0, hi_a_i} + {1'b0, hi_b_i};
  assign sum1 = {1'b0, hi_a_i} + {1'b0, hi_b_i} + 1'b1;

  assign cin   = cpa_first_i ? tail_carry_i : slice_carry_r;
  assign slice = cin ? sum1 : sum0;

  assign low_cat  = {tail_sum_i, low_r};
  assign high_cat = {slice[`MUL_CPA_STRIDE-1:0], high_r};

  always_ff @(posedge clk_i) begin
    if (calc_i || cpa_first_i) begin
      low_r <= low_cat[`MUL_WIDTH+`MUL_STRIDE-1:`MUL_STRIDE];
    end
    if (cpa_i) begin
      high_r <= high_cat[`MUL_WIDTH+`MUL_CPA_STRIDE-1:`MUL_CPA_STRIDE];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) slice_carry_r <= 1'b0;
    else if (cpa_i) slice_carry_r <= slice[`MUL_CPA_STRIDE];
  end

  assign result_o = {high_r, low_r};

endmodule

`default_nettype wire

/* hdl/booth_mul_top.sv */
// iterative radix-4 booth multiplier, signed or unsigned
// unpipelined, ready_o/v_i in and v_o/yumi_i out
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module booth_mul_top import mul_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_i,
  input  logic [`MUL_WIDTH-1:0]   opa_i,
  input  logic [`MUL_WIDTH-1:0]   opb_i,
  input  logic                    signed_i,
  input  logic                    yumi_i,
  output logic                    ready_o,
  output logic                    v_o,
  output logic [2*`MUL_WIDTH-1:0] result_o
);

  logic                             load;
  logic                             calc;
  logic                             cpa_first;
  logic                             cpa;
  logic [`MUL_WIDTH:0]              opa_ext;
  booth_digit_e [`MUL_STRIDE/2-1:0] digits;
  logic                             sign_fix;
  logic [`MUL_WIDTH+3:0]            first_pp;
  logic [`MUL_STRIDE-1:0]           tail_sum;
  logic                             tail_carry;
  logic [`MUL_CPA_STRIDE-1:0]       hi_a;
  logic [`MUL_CPA_STRIDE-1:0]       hi_b;

  mul_sequencer u_seq (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .v_i        (v_i),
    .yumi_i     (yumi_i),
    .ready_o    (ready_o),
    .v_o        (v_o),
    .load_o     (load),
    .calc_o     (calc),
    .cpa_first_o(cpa_first),
    .cpa_o      (cpa)
  );

  booth_recoder u_rec (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .load_i    (load),
    .calc_i    (calc),
    .opa_i     (opa_i),
    .opb_i     (opb_i),
    .signed_i  (signed_i),
    .opa_ext_o (opa_ext),
    .digits_o  (digits),
    .sign_fix_o(sign_fix),
    .first_pp_o(first_pp)
  );

  csa_accumulator u_acc (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_i      (load),
    .calc_i      (calc),
    .cpa_i       (cpa),
    .opa_ext_i   (opa_ext),
    .digits_i    (digits),
    .sign_fix_i  (sign_fix),
    .first_pp_i  (first_pp),
    .tail_sum_o  (tail_sum),
    .tail_carry_o(tail_carry),
    .hi_a_o      (hi_a),
    .hi_b_o      (hi_b)
  );

  result_cpa u_cpa (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .calc_i      (calc),
    .cpa_first_i (cpa_first),
    .cpa_i       (cpa),
    .tail_sum_i  (tail_sum),
    .tail_carry_i(tail_carry),
    .hi_a_i      (hi_a),
    .hi_b_i      (hi_b),
    .result_o    (result_o)
  );

endmodule

`default_nettype wire

/* tests/booth_mul_checker.sv */
// handshake assertions, bound into booth_mul_top
// all checks are disabled while reset is high
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module booth_mul_checker (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    yumi_i,
  input logic                    ready_o,
  input logic                    v_o,
  input logic [2*`MUL_WIDTH-1:0] result_o
);

  int fail_count;

  initial fail_count = 0;

  a_ready_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(v_o && ready_o))
    else begin
      $error("v_o and ready_o high together");
      fail_count++;
    end

  // back-pressure holds the product
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(result_o)))
    else begin
      $error("result_o or v_o changed while yumi_i was low");
      fail_count++;
    end

  a_retire: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && yumi_i) |=> (!v_o && ready_o))
    else begin
      $error("unit did not return to idle after yumi_i");
      fail_count++;
    end

endmodule

bind booth_mul_top booth_mul_checker i_checker (.*);

`default_nettype wire

/* tests/booth_mul_tb.sv */
// vectors come from tests/booth_mul_tests.dat, run from the project root
// one product in flight, yumi_i held off by the file delay plus 0..3 random cycles
`default_nettype none
`timescale 1ns/10ps
`include "mul_config.svh"

module booth_mul_tb;

  localparam int w_lp       = `MUL_WIDTH;
  localparam int latency_lp = `MUL_WIDTH / `MUL_STRIDE + `MUL_WIDTH / `MUL_CPA_STRIDE;
  localparam int timeout_lp = 64; // cycles allowed per wait

  logic              clk_i;
  logic              reset_i;
  logic              v_i;
  logic [w_lp-1:0]   opa_i;
  logic [w_lp-1:0]   opb_i;
  logic              signed_i;
  logic              yumi_i;
  logic              ready_o;
  logic              v_o;
  logic [2*w_lp-1:0] result_o;

  booth_mul_top i_booth_mul_top (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (v_i),
    .opa_i   (opa_i),
    .opb_i   (opb_i),
    .signed_i(signed_i),
    .yumi_i  (yumi_i),
    .ready_o (ready_o),
    .v_o     (v_o),
    .result_o(result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_failed(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped on first error");
  endtask

  task automatic check(input string name, input logic [2*w_lp-1:0] got,
                       input logic [2*w_lp-1:0] exp);
    if (got !== exp) begin
      stop_failed($sformatf("Mismatch at %0t ns: %s got 0x%h expected 0x%h",
                            $time, name, got, exp));
    end
  endtask

  // true product of the two operands
  function automatic logic [2*w_lp-1:0] model_product(input logic [w_lp-1:0] a,
                                                      input logic [w_lp-1:0] b,
                                                      input logic s);
    logic signed [2*w_lp-1:0] sa;
    logic signed [2*w_lp-1:0] sb;
    sa = s ? {{w_lp{a[w_lp-1]}}, a} : {{w_lp{1'b0}}, a};
    sb = s ? {{w_lp{b[w_lp-1]}}, b} : {{w_lp{1'b0}}, b};
    return sa * sb;
  endfunction

  // called at a falling edge
  task automatic wait_ready();
    int n;
    n = 0;
    while (ready_o !== 1'b1) begin
      @(negedge clk_i);
      n++;
      if (n > timeout_lp) stop_failed("timeout while waiting for ready_o");
    end
  endtask

  task automatic run_vector(input logic [w_lp-1:0] a, input logic [w_lp-1:0] b,
                            input logic s, input logic [2*w_lp-1:0] exp,
                            input int hold);
    int edges;
    int extra;
    wait_ready();
    @(posedge clk_i);
    v_i      <= 1'b1;
    opa_i    <= a;
    opb_i    <= b;
    signed_i <= s;
    @(posedge clk_i); // accept edge
    v_i <= 1'b0;
    @(negedge clk_i);
    check("ready_o after accept", ready_o, 0);
    edges = 0;
    while (v_o !== 1'b1) begin
      @(posedge clk_i);
      edges++;
      if (edges == 2) begin
        v_i   <= 1'b1; // must be ignored while busy
        opa_i <= ~a;
        opb_i <= a ^ b;
      end else begin
        v_i <= 1'b0;
      end
      @(negedge clk_i);
      if (edges > timeout_lp) stop_failed("timeout while waiting for v_o");
    end
    check("v_o latency in edges", edges, latency_lp);
    check("result_o", result_o, exp);
    extra = $urandom % 4;
    repeat (hold + extra) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check("v_o under back-pressure", v_o, 1);
      check("result_o under back-pressure", result_o, exp);
    end
    @(posedge clk_i);
    yumi_i <= 1'b1;
    @(posedge clk_i); // retire edge
    yumi_i <= 1'b0;
    @(negedge clk_i);
    check("v_o after yumi_i", v_o, 0);
    check("ready_o after yumi_i", ready_o, 1);
  endtask

  initial begin
    int                fd;
    int                n;
    int                sflag;
    int                hold;
    int                nvec;
    string             line;
    logic [w_lp-1:0]   a;
    logic [w_lp-1:0]   b;
    logic [2*w_lp-1:0] exp;
    reset_i  = 1'b1;
    v_i      = 1'b0;
    opa_i    = '0;
    opb_i    = '0;
    signed_i = 1'b0;
    yumi_i   = 1'b0;
    void'($urandom(32'hda1));
    nvec     = 0;
    fd = $fopen("tests/booth_mul_tests.dat", "r");
    if (fd == 0) stop_failed("cannot open tests/booth_mul_tests.dat");
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check("ready_o after reset", ready_o, 1);
    check("v_o after reset", v_o, 0);
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 0 && line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %d", a, b, sflag, exp, hold);
      if (n <= 0) continue; // blank line
      if (n != 5) stop_failed({"malformed vector line: ", line});
      check("file expected vs model", exp, model_product(a, b, sflag[0]));
      run_vector(a, b, sflag[0], exp, hold);
      nvec++;
    end
    $fclose(fd);
    if (nvec == 0) stop_failed("no vectors found in tests/booth_mul_tests.dat");
    if (i_booth_mul_top.i_checker.fail_count == 0) begin
      $display("%0d vectors run", nvec);
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("%0d assertion failures", i_booth_mul_top.i_checker.fail_count);
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failures seen");
    end
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/mul_pkg.sv
hdl/mul_sequencer.sv
hdl/booth_selector.sv
hdl/booth_recoder.sv
hdl/csa_accumulator.sv
hdl/result_cpa.sv
hdl/booth_mul_top.sv
tests/booth_mul_checker.sv
tests/booth_mul_tb.sv

/* tests/booth_mul_tests.dat */
# opa opb signed expected_product hold_cycles
# hex operands and product, signed 0/1, hold in decimal cycles before yumi_i
00000000 00000000 0 0000000000000000 0
FFFFFFFF FFFFFFFF 0 FFFFFFFE00000001 2
80000000 80000000 0 4000000000000000 0
80000000 00000003 0 0000000180000000 1
12345678 00000010 0 0000000123456780 0
0000FFFF 0000FFFF 0 00000000FFFE0001 3
FFFFFFFF 7FFFFFFF 0 7FFFFFFE80000001 0
DEADBEEF 00000001 0 00000000DEADBEEF 0
00001234 00005678 0 0000000006260060 1
80000000 80000000 1 4000000000000000 0
FFFFFFFF 00000007 1 FFFFFFFFFFFFFFF9 1
FFFFFFFF FFFFFFFF 1 0000000000000001 0
7FFFFFFF 80000000 1 C000000080000000 2
FFFFFFFE 00000003 1 FFFFFFFFFFFFFFFA 0
00000005 FFFFFFFD 1 FFFFFFFFFFFFFFF1 0
7FFFFFFF 7FFFFFFF 1 3FFFFFFF00000001 1
80000000 FFFFFFFF 1 0000000080000000 0
DEADBEEF 00000001 1 FFFFFFFFDEADBEEF 0
FFFFEDCC 00005678 1 FFFFFFFFF9D9FFA0 2
00010000 00010000 1 0000000100000000 0
